// ==== Makefile ====
# Verilator simulation of the pooling unit

VERILATOR ?= verilator
TOP       ?= pool_tb
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): sim.f source/*.sv tests/*.sv tests/*.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f sim.f

run: compile
	$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ]; then exit 1; fi; \
	if grep -q "tests failed" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== sim.f ====
+incdir+tests
source/pool_pkg.sv
source/pool_cmd_decode.sv
source/pool_window_engine.sv
source/pool_result_sender.sv
source/pool_top.sv
tests/pool_tb.sv

// ==== source/pool_cmd_decode.sv ====
`default_nettype none
`timescale 1ns/1ns

module pool_cmd_decode #(
    parameter int MAX_W = 64  // widest row the engine buffer holds
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                cmd_valid,
    input  pool_pkg::pool_cmd_t cmd,
    input  logic                frame_end,
    output logic                cmd_ready,
    output logic                cmd_err,
    output logic                start,
    output pool_pkg::pool_cfg_t cfg,
    output logic                frame_done
);
    import pool_pkg::*;

    logic busy;      // a frame is active
    logic take;      // command handshake this cycle
    logic bad_size;  // odd, zero or too wide
    logic bad_op;    // opcode outside the enum
    logic err_q;     // first stage of the error pulse

    assign cmd_ready = !busy;  // one command slot, no queue
    assign take      = cmd_valid && cmd_ready;

    //////////////////////////////
    // command checks
    //////////////////////////////

    // 2x2 stride 2 needs even sizes on both axes
    assign bad_size = cmd.width[0] || cmd.height[0]
                   || (cmd.width == 8'd0) || (cmd.height == 8'd0)
                   || (int'(cmd.width) > MAX_W);  // partial row would not fit

    assign bad_op = (cmd.op != POOL_MAX) && (cmd.op != POOL_AVG);

    //////////////////////////////
    // busy flag, start and config
    //////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy       <= 1'b0;
            start      <= 1'b0;
            err_q      <= 1'b0;
            cmd_err    <= 1'b0;
            frame_done <= 1'b0;
            cfg        <= '{op: POOL_MAX, half_w: 7'd0, half_h: 7'd0};
        end else begin
            start      <= 1'b0;  // single cycle pulses by default
            err_q      <= 1'b0;
            cmd_err    <= err_q;  // error shows two cycles after acceptance
            frame_done <= frame_end;  // one more register after the engine
            if (take) begin
                if (bad_size || bad_op) begin
                    err_q <= 1'b1;  // nothing starts, slot stays free
                end else begin
                    busy       <= 1'b1;
                    start      <= 1'b1;
                    cfg.op     <= pool_op_e'(cmd.op);
                    cfg.half_w <= cmd.width[7:1];   // output columns
                    cfg.half_h <= cmd.height[7:1];  // output rows
                end
            end else if (frame_end) begin
                busy <= 1'b0;  // engine finished the last window
            end
        end
    end

    // the engine only ends a frame that this decoder started
    frame_end_in_busy_a: assert property (
        @(posedge clk) disable iff (rst) frame_end |-> busy
    ) else $error("frame_end seen with no active frame");

endmodule

`default_nettype wire

// ==== source/pool_pkg.sv ====
`default_nettype none

//////////////////////////////
// shared types for the 2x2 pooling unit
//////////////////////////////

package pool_pkg;

    // pixel format, unsigned only
    localparam int PIX_W = 8;

    typedef logic [PIX_W-1:0] pixel_t;  // one feature map pixel

    //////////////////////////////
    // opcodes and engine states
    //////////////////////////////

    // 2-bit field, codes 2 and 3 are rejected by the decoder
    typedef enum logic [1:0] {
        POOL_MAX = 2'd0,  // largest of the four pixels
        POOL_AVG = 2'd1   // sum of four, shifted right by two
    } pool_op_e;

    typedef enum logic [1:0] {
        IDLE  = 2'd0,  // waiting for start
        RUN   = 2'd1,  // popping pixels, building windows
        FLUSH = 2'd2   // last window pushed, back to idle next
    } eng_state_e;

    //////////////////////////////
    // command, config and result
    //////////////////////////////

    // raw command as it arrives on the command port
    typedef struct packed {
        logic [1:0] op;      // raw opcode, may be invalid
        logic [7:0] width;   // pixels per row
        logic [7:0] height;  // rows in the map
    } pool_cmd_t;

    // checked configuration, held for the whole frame
    typedef struct packed {
        pool_op_e   op;
        logic [6:0] half_w;  // output columns
        logic [6:0] half_h;  // output rows
    } pool_cfg_t;

    // one pooled value toward the consumer
    typedef struct packed {
        pixel_t value;
        logic   last;  // final window of the frame
    } pool_result_t;

endpackage

`default_nettype wire

// ==== source/pool_result_sender.sv ====
`default_nettype none
`timescale 1ns/1ns

module pool_result_sender #(
    parameter int OUT_DEPTH   = 4,  // result FIFO entries
    parameter int OUT_CREDITS = 4   // results the consumer can absorb
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   res_push,
    input  pool_pkg::pool_result_t res_in,
    input  logic                   res_credit,
    output logic                   room,
    output logic                   res_valid,
    output pool_pkg::pool_result_t res
);
    import pool_pkg::*;

    localparam int PTR_W = (OUT_DEPTH > 1) ? $clog2(OUT_DEPTH) : 1;
    localparam int CNT_W = $clog2(OUT_DEPTH + 1);
    localparam int CRD_W = $clog2(OUT_CREDITS + 2);  // one spare value so overflow shows

    pool_result_t     res_mem [OUT_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] fill;
    logic [CRD_W-1:0] credits;  // results the consumer still accepts

    //////////////////////////////
    // result FIFO
    //////////////////////////////

    // two free slots, one more result may sit in the engine register
    assign room = (int'(fill) + 2 <= OUT_DEPTH);

    always_ff @(posedge clk) begin
        if (res_push) res_mem[wr_ptr] <= res_in;
    end

    assign res       = res_mem[rd_ptr];
    assign res_valid = (fill != '0) && (credits != '0);  // each beat spends a credit

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (res_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(OUT_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (res_valid) begin
                rd_ptr <= (rd_ptr == PTR_W'(OUT_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            fill <= fill + CNT_W'(res_push) - CNT_W'(res_valid);
        end
    end

    //////////////////////////////
    // output credits
    //////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            credits <= CRD_W'(OUT_CREDITS);  // consumer starts empty
        end else begin
            case ({res_credit, res_valid})
                2'b10:   credits <= credits + 1'b1;  // returned, nothing sent
                2'b01:   credits <= credits - 1'b1;  // sent, nothing returned
                default: credits <= credits;         // both or neither
            endcase
        end
    end

    // the consumer never returns more than it was given
    credit_bound_a: assert property (
        @(posedge clk) disable iff (rst) credits <= CRD_W'(OUT_CREDITS)
    ) else $error("output credit count above the consumer capacity");

    // room drops early enough that the engine never pushes into a full FIFO
    no_push_when_full_a: assert property (
        @(posedge clk) disable iff (rst) res_push |-> (fill != CNT_W'(OUT_DEPTH))
    ) else $error("result pushed into a full result FIFO");

endmodule

`default_nettype wire

// ==== source/pool_top.sv ====
`default_nettype none
`timescale 1ns/1ns

module pool_top #(
    parameter int MAX_W       = 64,
    parameter int IN_DEPTH    = 8,  // also the source credit count
    parameter int OUT_DEPTH   = 4,
    parameter int OUT_CREDITS = 4
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cmd_valid,
    input  pool_pkg::pool_cmd_t    cmd,
    input  logic                   pix_valid,
    input  pool_pkg::pixel_t       pix,
    input  logic                   res_credit,
    output logic                   cmd_ready,
    output logic                   cmd_err,
    output logic                   pix_credit,
    output logic                   res_valid,
    output pool_pkg::pool_result_t res,
    output logic                   frame_done
);
    import pool_pkg::*;

    logic         start;      // decode to engine
    pool_cfg_t    cfg;        // held for the frame
    logic         frame_end;  // engine back to decode
    logic         room;       // sender can take two more
    logic         res_push;
    pool_result_t eng_res;

    // command check and busy tracking
    pool_cmd_decode #(.MAX_W(MAX_W)) decode_i (
        .clk, .rst, .cmd_valid, .cmd, .frame_end,
        .cmd_ready, .cmd_err, .start, .cfg, .frame_done
    );

    // input FIFO and window math
    pool_window_engine #(.MAX_W(MAX_W), .IN_DEPTH(IN_DEPTH)) engine_i (
        .clk, .rst, .start, .cfg, .pix_valid, .pix, .room,
        .pix_credit, .res_push, .res(eng_res), .frame_end
    );

    // result FIFO toward the consumer
    pool_result_sender #(.OUT_DEPTH(OUT_DEPTH), .OUT_CREDITS(OUT_CREDITS)) sender_i (
        .clk, .rst, .res_push, .res_in(eng_res), .res_credit,
        .room, .res_valid, .res
    );

endmodule

`default_nettype wire

// ==== source/pool_window_engine.sv ====
`default_nettype none
`timescale 1ns/1ns

module pool_window_engine #(
    parameter int MAX_W    = 64,  // sizes the partial row buffer
    parameter int IN_DEPTH = 8    // input FIFO depth, equals source credits
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  pool_pkg::pool_cfg_t    cfg,
    input  logic                   pix_valid,
    input  pool_pkg::pixel_t       pix,
    input  logic                   room,
    output logic                   pix_credit,
    output logic                   res_push,
    output pool_pkg::pool_result_t res,
    output logic                   frame_end
);
    import pool_pkg::*;

    localparam int PTR_W = (IN_DEPTH > 1) ? $clog2(IN_DEPTH) : 1;
    localparam int CNT_W = $clog2(IN_DEPTH + 1);
    localparam int BUF_N = MAX_W / 2;  // one partial per output column
    localparam int BUF_A = (BUF_N > 1) ? $clog2(BUF_N) : 1;

    // input FIFO
    pixel_t           fifo_mem [IN_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] fill;
    pixel_t           head;  // oldest pixel
    logic             pop;

    // window state
    eng_state_e       state;
    logic             x_odd;     // second pixel of a pair
    logic             row_odd;   // bottom row of a window
    logic [6:0]       pair_col;  // output column
    logic [6:0]       row_pair;  // output row
    pixel_t           left_pix;  // first pixel of the current pair
    logic [PIX_W:0]   row_buf [BUF_N];  // partials of the top row
    logic [BUF_A-1:0] buf_idx;
    logic [PIX_W:0]   pair_part;  // max or 9-bit sum of the pair
    logic [PIX_W:0]   stored;     // partial from the row above
    logic [PIX_W+1:0] avg_sum;    // all four pixels
    pixel_t           pair_max;
    pixel_t           pooled;
    logic             last_col;
    logic             last_row;
    logic             last_win;

    //////////////////////////////
    // input FIFO, credit backed
    //////////////////////////////

    assign head = fifo_mem[rd_ptr];
    assign pop  = (state == RUN) && (fill != '0) && room;  // stall on full result FIFO

    always_ff @(posedge clk) begin
        if (pix_valid) fifo_mem[wr_ptr] <= pix;  // no ready, credits guarantee space
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fill       <= '0;
            pix_credit <= 1'b0;
        end else begin
            if (pix_valid) begin
                wr_ptr <= (wr_ptr == PTR_W'(IN_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(IN_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            fill       <= fill + CNT_W'(pix_valid) - CNT_W'(pop);
            pix_credit <= pop;  // credit goes back the cycle after the pop
        end
    end

    //////////////////////////////
    // window arithmetic
    //////////////////////////////

    assign buf_idx  = pair_col[BUF_A-1:0];
    assign stored   = row_buf[buf_idx];
    assign pair_max = (head > left_pix) ? head : left_pix;

    // top row keeps the max for max mode, the full sum for average mode
    assign pair_part = (cfg.op == POOL_AVG) ? ({1'b0, head} + {1'b0, left_pix})
                                            : {1'b0, pair_max};
    assign avg_sum   = {1'b0, stored} + {1'b0, pair_part};

    always_comb begin
        if (cfg.op == POOL_AVG) begin
            pooled = avg_sum[PIX_W+1:2];  // divide by four, truncating
        end else begin
            pooled = (stored[PIX_W-1:0] > pair_max) ? stored[PIX_W-1:0] : pair_max;
        end
    end

    assign last_col = (pair_col == cfg.half_w - 7'd1);
    assign last_row = (row_pair == cfg.half_h - 7'd1);
    assign last_win = x_odd && row_odd && last_col && last_row;  // bottom right of frame

    // pair and partial registers
    always_ff @(posedge clk) begin
        if (pop && !x_odd) left_pix <= head;
        if (pop && x_odd && !row_odd) row_buf[buf_idx] <= pair_part;
        if (pop && x_odd && row_odd) begin
            res.value <= pooled;
            res.last  <= last_win;
        end
    end

    //////////////////////////////
    // FSM and counters
    //////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= IDLE;
            x_odd     <= 1'b0;
            row_odd   <= 1'b0;
            pair_col  <= '0;
            row_pair  <= '0;
            res_push  <= 1'b0;
            frame_end <= 1'b0;
        end else begin
            res_push  <= pop && x_odd && row_odd;  // one cycle after bottom-right pop
            frame_end <= pop && last_win;
            case (state)
                IDLE: begin
                    if (start) begin
                        state    <= RUN;
                        x_odd    <= 1'b0;
                        row_odd  <= 1'b0;
                        pair_col <= '0;
                        row_pair <= '0;
                    end
                end
                RUN: begin
                    if (pop) begin
                        x_odd <= !x_odd;
                        if (x_odd) begin
                            if (last_col) begin  // end of an input row
                                pair_col <= '0;
                                row_odd  <= !row_odd;
                                if (row_odd) row_pair <= row_pair + 7'd1;
                            end else begin
                                pair_col <= pair_col + 7'd1;
                            end
                        end
                        if (last_win) state <= FLUSH;
                    end
                end
                FLUSH:   state <= IDLE;  // last result and frame_end leave here
                default: state <= IDLE;
            endcase
        end
    end

    // source spends a credit per pixel, so a full FIFO never sees a write
    in_fifo_no_overflow_a: assert property (
        @(posedge clk) disable iff (rst) pix_valid |-> (fill != CNT_W'(IN_DEPTH))
    ) else $error("pixel written into a full input FIFO");

    // decoder holds busy until frame_end, so a start only finds the engine idle
    start_when_idle_a: assert property (
        @(posedge clk) disable iff (rst) start |-> (state == IDLE)
    ) else $error("start while a frame is still running");

endmodule

`default_nettype wire

// ==== tests/pool_tb_ref.svh ====
`ifndef POOL_TB_REF_SVH
`define POOL_TB_REF_SVH

//////////////////////////////
// reference pooling model
//////////////////////////////

// expected results of one frame, appended to exp_q in raster order
// frame pixels start at frame_mem[base], row by row, w pixels per row
function automatic void pool_ref(input int op, input int w, input int h, input int base);
    int           r;
    int           c;
    int           p0;
    int           p1;
    int           p2;
    int           p3;
    int           top;  // index of the top-left pixel
    int           m;
    pool_result_t item;
    for (r = 0; r < h / 2; r++) begin
        for (c = 0; c < w / 2; c++) begin
            top = base + (2 * r) * w + 2 * c;
            p0  = frame_mem[top];
            p1  = frame_mem[top + 1];
            p2  = frame_mem[top + w];
            p3  = frame_mem[top + w + 1];
            if (op == 1) begin
                m = (p0 + p1 + p2 + p3) / 4;  // truncating mean
            end else begin
                m = p0;
                if (p1 > m) m = p1;
                if (p2 > m) m = p2;
                if (p3 > m) m = p3;
            end
            item.value = m[7:0];
            // only the bottom-right window of the frame is marked
            item.last  = (r == h / 2 - 1) && (c == w / 2 - 1);
            exp_q.push_back(item);
        end
    end
endfunction

`endif

// ==== tests/pool_tb.sv ====
`default_nettype none
`timescale 1ns/1ns

module pool_tb;
    import pool_pkg::*;

    localparam int IN_DEPTH    = 8;
    localparam int OUT_CREDITS = 4;
    localparam int TMO         = 4000;  // cycles per wait

    logic         clk;
    logic         rst;
    logic         cmd_valid;
    pool_cmd_t    cmd;
    logic         pix_valid;
    pixel_t       pix;
    logic         res_credit;
    logic         cmd_ready;
    logic         cmd_err;
    logic         pix_credit;
    logic         res_valid;
    pool_result_t res;
    logic         frame_done;

    pixel_t       frame_mem [0:4095];
    pool_result_t exp_q[$];
    integer       seed = 32'h8f8e5485;
    int           src_credits = IN_DEPTH;
    int           owed;        // beats received, credit not yet returned
    int           hold;        // sink withholds credits
    int           slow;        // idle cycles between returned credits
    int           gap_cnt;
    int           errors;
    int           done_cnt;
    int           err_cnt;
    int           n_pass;
    int           n_fail;
    string        cur_test;

    `include "pool_tb_ref.svh"

    pool_top dut_i (
        .clk, .rst, .cmd_valid, .cmd, .pix_valid, .pix, .res_credit,
        .cmd_ready, .cmd_err, .pix_credit, .res_valid, .res, .frame_done
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = !clk;
    end

    //////////////////////////////
    // compare and monitors
    //////////////////////////////

    always @(negedge clk) begin
        if (!rst) begin
            if (pix_credit) begin
                src_credits++;
                assert (src_credits <= IN_DEPTH) else begin
                    $display("%s: more pixel credits returned than pixels sent", cur_test);
                    errors++;
                end
            end
            if (frame_done) done_cnt++;
            if (cmd_err) err_cnt++;
            if (res_valid) begin
                owed++;
                assert (owed <= OUT_CREDITS) else begin
                    $display("%s: more results sent than credits granted", cur_test);
                    errors++;
                end
                assert (exp_q.size() > 0) else begin
                    $display("%s: result arrived with none expected", cur_test);
                    errors++;
                end
                if (exp_q.size() > 0) begin
                    assert (res == exp_q[0]) else begin
                        $display("ERROR %s expected %h last %0d actual %h last %0d", cur_test,
                                 exp_q[0].value, exp_q[0].last, res.value, res.last);
                        errors++;
                    end
                    void'(exp_q.pop_front());
                end
            end
        end
    end

    // credit-returning sink
    always @(posedge clk) begin
        #1;
        res_credit = 1'b0;
        if (!hold && owed > 0) begin
            if (gap_cnt >= slow) begin
                res_credit = 1'b1;
                owed--;
                gap_cnt = 0;
            end else begin
                gap_cnt++;
            end
        end
    end

    //////////////////////////////
    // helper tasks
    //////////////////////////////

    task automatic abort_run(input string why);
        $display("%s: %s", cur_test, why);
        $display("tests failed");
        $finish;
    endtask

    task automatic issue_cmd(input int op, input int w, input int h);
        int t;
        t = 0;
        while (!cmd_ready) begin
            @(posedge clk);
            if (++t > TMO) abort_run("cmd_ready never came back");
        end
        @(posedge clk);
        #1 cmd_valid = 1'b1;
        cmd = '{op: op[1:0], width: w[7:0], height: h[7:0]};
        @(posedge clk);
        #1 cmd_valid = 1'b0;
    endtask

    task automatic send_frame(input int base, input int n, input bit gaps);
        int i;
        int t;
        i = 0;
        t = 0;
        while (i < n) begin
            @(posedge clk);
            #1 pix_valid = 1'b0;
            if (src_credits > 0 && !(gaps && ({$random(seed)} % 3 == 0))) begin
                pix_valid = 1'b1;  // only ever sent while a credit is held
                pix = frame_mem[base + i];
                src_credits--;
                i++;
                t = 0;
            end else if (++t > TMO) begin
                abort_run("pixel source starved of credits");
            end
        end
        @(posedge clk);
        #1 pix_valid = 1'b0;
    endtask

    task automatic fill_frame(input int base, input int n);
        int i;
        for (i = 0; i < n; i++) frame_mem[base + i] = pixel_t'($random(seed));
    endtask

    task automatic wait_drain(input int frames);
        int t;
        t = 0;
        while (exp_q.size() > 0 || done_cnt < frames) begin
            @(posedge clk);
            if (++t > TMO) abort_run("results or frame_done did not arrive");
        end
    endtask

    task automatic run_frame(input int op, input int w, input int h, input bit gaps);
        fill_frame(0, w * h);
        pool_ref(op, w, h, 0);
        done_cnt = 0;
        issue_cmd(op, w, h);
        send_frame(0, w * h, gaps);
        wait_drain(1);
    endtask

    task automatic bad_cmd(input int op, input int w, input int h);
        int t;
        err_cnt = 0;
        issue_cmd(op, w, h);
        t = 0;
        while (err_cnt == 0) begin
            @(negedge clk);
            if (++t > 20) abort_run("no cmd_err for an invalid command");
        end
        repeat (5) @(negedge clk);
        assert (cmd_ready) else begin
            $display("%s: invalid command left the unit busy", cur_test);
            errors++;
        end
        assert (err_cnt == 1) else begin
            $display("%s: cmd_err pulse longer than one cycle", cur_test);
            errors++;
        end
    endtask

    task automatic end_test();
        if (errors == 0) n_pass++;
        else n_fail++;
        $display("test %s: %s", cur_test, (errors == 0) ? "ok" : "FAILED");
        errors = 0;
    endtask

    //////////////////////////////
    // test sequence
    //////////////////////////////

    initial begin
        rst = 1'b1;
        cmd_valid = 1'b0;
        cmd = '0;
        pix_valid = 1'b0;
        pix = '0;
        res_credit = 1'b0;
        hold = 0;
        slow = 0;
        owed = 0;
        gap_cnt = 0;
        errors = 0;
        n_pass = 0;
        n_fail = 0;
        cur_test = "reset";
        repeat (16) @(posedge clk);
        #1 rst = 1'b0;

        cur_test = "max_8x6";
        run_frame(0, 8, 6, 1'b1);
        end_test();

        cur_test = "avg_10x4";
        run_frame(1, 10, 4, 1'b1);
        end_test();

        cur_test = "backpressure";
        hold = 1;
        slow = 6;  // trickle of credits after the hold
        fork
            begin
                repeat (300) @(posedge clk);
                hold = 0;
            end
        join_none
        run_frame(0, 16, 4, 1'b0);
        slow = 0;
        end_test();

        cur_test = "invalid_cmds";
        bad_cmd(0, 7, 4);    // odd width
        bad_cmd(0, 8, 0);    // zero height
        bad_cmd(1, 66, 2);   // wider than MAX_W
        bad_cmd(3, 4, 4);    // undefined opcode
        end_test();

        cur_test = "back_to_back";
        fill_frame(0, 16);
        fill_frame(16, 128);
        pool_ref(0, 4, 4, 0);
        pool_ref(1, 64, 2, 16);
        done_cnt = 0;
        issue_cmd(0, 4, 4);
        assert (!cmd_ready) else begin
            $display("%s: cmd_ready high during an active frame", cur_test);
            errors++;
        end
        send_frame(0, 16, 1'b1);
        issue_cmd(1, 64, 2);
        send_frame(16, 128, 1'b1);
        wait_drain(2);
        end_test();

        $display("passed %0d failed %0d", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
